// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_tx_transport
FILELIST   = sim.f
OBJ_DIR    = obj_dir
SIM_BIN    = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/csr_decode.sv
// Registers csr_n and csr_l into one-hot resolution selects and a lane power-down mask
`timescale 1ns/1ps

module csr_decode (
   input  logic                                   txframe_clk,
   input  logic                                   txframe_rst_n,
   input  logic [tx_transport_pkg::CSR_L_W-1:0]   csr_l,
   input  logic [tx_transport_pkg::CSR_N_W-1:0]   csr_n,
   output logic [tx_transport_pkg::NUM_RES-1:0]   n_sel,
   output logic [tx_transport_pkg::NUM_LANES-1:0] pdlane
);

   import tx_transport_pkg::*;

   logic [NUM_RES-1:0]   n_sel_next;
   logic [NUM_LANES-1:0] pdlane_next;

   //////////////////////////////////////////////////
   // Next-state decode
   //////////////////////////////////////////////////

   // csr_n holds N minus one, so flag r matches N_MIN + r
   always_comb
   begin
      for (int r = 0; r < NUM_RES; r++)
      begin
         n_sel_next[r] = (csr_n == CSR_N_W'(N_MIN - 1 + r));
      end
   end

   // Lanes above csr_l are powered down
   always_comb
   begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
         pdlane_next[i] = (CSR_L_W'(i) > csr_l);
      end
   end

   //////////////////////////////////////////////////
   // Registered outputs
   //////////////////////////////////////////////////

   always_ff @(posedge txframe_clk)
   begin
      if (!txframe_rst_n)
      begin
         n_sel  <= '0;
         pdlane <= '0;
      end
      else
      begin
         n_sel  <= n_sel_next;
         pdlane <= pdlane_next;
      end
   end

endmodule

// File: hw/lane_mapper.sv
// Maps slot pairs onto 32-bit lane words and blanks powered-down lanes or not-ready cycles
`timescale 1ns/1ps

module lane_mapper (
   input  logic [tx_transport_pkg::DATAIN_W-1:0]  slot_bus,
   input  logic [tx_transport_pkg::NUM_LANES-1:0] pdlane,
   input  logic                                   ready_d1,
   output logic [tx_transport_pkg::LINK_W-1:0]    lane_bus
);

   import tx_transport_pkg::*;

   logic [LINK_W-1:0] lane_raw;

   //////////////////////////////////////////////////
   // F=4 octet mapping
   //////////////////////////////////////////////////

   // Lane i gets slot 2i in the upper half, slot 2i+1 in the lower
   for (genvar i = 0; i < NUM_LANES; i++)
   begin : g_lane
      assign lane_raw[i*LANE_W +: LANE_W] = {slot_bus[(2*i)*SLOT_W +: SLOT_W],
                                             slot_bus[(2*i+1)*SLOT_W +: SLOT_W]};
   end

   // Unused lanes send zeros, as does everything before ready
   always_comb
   begin
      for (int i = 0; i < NUM_LANES; i++)
      begin
         if (pdlane[i] || !ready_d1)
         begin
            lane_bus[i*LANE_W +: LANE_W] = '0;
         end
         else
         begin
            lane_bus[i*LANE_W +: LANE_W] = lane_raw[i*LANE_W +: LANE_W];
         end
      end
   end

endmodule

// File: hw/link_output.sv
// Registers lane data toward the link layer, delays valid and raises the missing-data error flag
`timescale 1ns/1ps

module link_output (
   input  logic                                txframe_clk,
   input  logic                                txframe_rst_n,
   input  logic [tx_transport_pkg::LINK_W-1:0] lane_bus,
   input  logic                                jesd_tx_data_valid,
   input  logic                                ready_d1,
   output logic [tx_transport_pkg::LINK_W-1:0] tprt_link_txdata,
   output logic                                tprt_link_txdata_valid,
   output logic                                tprt_link_txdata_error
);

   import tx_transport_pkg::*;

   logic valid_d1;
   logic data_missing;

   // Link asks for data but the application has none
   assign data_missing = ready_d1 && !jesd_tx_data_valid;

   //////////////////////////////////////////////////
   // Output registers
   //////////////////////////////////////////////////

   always_ff @(posedge txframe_clk)
   begin
      if (!txframe_rst_n)
      begin
         tprt_link_txdata <= '0;
      end
      else
      begin
         tprt_link_txdata <= lane_bus;
      end
   end

   // Valid lags the application by two cycles
   always_ff @(posedge txframe_clk)
   begin
      if (!txframe_rst_n)
      begin
         valid_d1               <= 1'b0;
         tprt_link_txdata_valid <= 1'b0;
      end
      else
      begin
         valid_d1               <= jesd_tx_data_valid;
         tprt_link_txdata_valid <= valid_d1;
      end
   end

   // No stall here, the link only hears about the gap
   always_ff @(posedge txframe_clk)
   begin
      if (!txframe_rst_n)
      begin
         tprt_link_txdata_error <= 1'b0;
      end
      else
      begin
         tprt_link_txdata_error <= data_missing;
      end
   end

endmodule

// File: hw/sample_packer.sv
// Packs N-bit converter samples into the top of 16-bit slots for the resolution selected by n_sel
`timescale 1ns/1ps

module sample_packer (
   input  logic [tx_transport_pkg::DATAIN_W-1:0] jesd_tx_datain,
   input  logic [tx_transport_pkg::NUM_RES-1:0]  n_sel,
   output logic [tx_transport_pkg::DATAIN_W-1:0] slot_bus
);

   import tx_transport_pkg::*;

   // One packed frame per supported resolution
   logic [DATAIN_W-1:0] build [NUM_RES];

   //////////////////////////////////////////////////
   // Tail-bit padding per resolution
   //////////////////////////////////////////////////

   for (genvar r = 0; r < NUM_RES; r++)
   begin : g_res
      localparam int N = N_MIN + r;

      for (genvar s = 0; s < SLOTS; s++)
      begin : g_slot
         if (N == SLOT_W)
         begin : g_full
            // Full-width samples already fill the slot
            assign build[r][s*SLOT_W +: SLOT_W] = jesd_tx_datain[s*N +: N];
         end
         else
         begin : g_pad
            assign build[r][s*SLOT_W +: SLOT_W] =
               {jesd_tx_datain[s*N +: N], {(SLOT_W-N){1'b0}}};
         end
      end
   end

   // At most one select is set, none gives zero
   always_comb
   begin
      slot_bus = '0;
      for (int r = 0; r < NUM_RES; r++)
      begin
         slot_bus = slot_bus | (build[r] & {DATAIN_W{n_sel[r]}});
      end
   end

endmodule

// File: hw/tx_transport_pkg.sv
// Shared lane, slot and resolution constants for the JESD204 transmit transport RTL and testbench
package tx_transport_pkg;

   //////////////////////////////////////////////////
   // Lane geometry
   //////////////////////////////////////////////////

   localparam int NUM_LANES = 4;
   localparam int LANE_W    = 32;

   // Two samples per lane, one frame per cycle
   localparam int SLOTS     = 8;
   localparam int SLOT_W    = 16;

   //////////////////////////////////////////////////
   // Sample resolution
   //////////////////////////////////////////////////

   localparam int N_MIN     = 12;
   localparam int N_MAX     = 16;
   localparam int NUM_RES   = N_MAX - N_MIN + 1;

   // Bus widths
   localparam int DATAIN_W  = SLOTS * SLOT_W;
   localparam int LINK_W    = NUM_LANES * LANE_W;

   // CSR field widths
   localparam int CSR_N_W   = 5;
   localparam int CSR_L_W   = 5;

endpackage

// File: hw/tx_transport_top.sv
// Top level of the JESD204 transmit transport layer, chaining CSR decode, packing, mapping and output
`timescale 1ns/1ps

module tx_transport_top (
   input  logic                                  txframe_clk,
   input  logic                                  txframe_rst_n,
   input  logic [tx_transport_pkg::DATAIN_W-1:0] jesd_tx_datain,
   input  logic                                  jesd_tx_data_valid,
   input  logic                                  link_tprt_early_txdata_ready,
   input  logic [tx_transport_pkg::CSR_L_W-1:0]  csr_l,
   input  logic [tx_transport_pkg::CSR_N_W-1:0]  csr_n,
   output logic                                  jesd_tx_data_ready,
   output logic [tx_transport_pkg::LINK_W-1:0]   tprt_link_txdata,
   output logic                                  tprt_link_txdata_valid,
   output logic                                  tprt_link_txdata_error
);

   logic                                   ready_d1;
   logic [tx_transport_pkg::NUM_RES-1:0]   n_sel;
   logic [tx_transport_pkg::NUM_LANES-1:0] pdlane;
   logic [tx_transport_pkg::DATAIN_W-1:0]  slot_bus;
   logic [tx_transport_pkg::LINK_W-1:0]    lane_bus;

   //////////////////////////////////////////////////
   // Ready echo, shared by mapper and output stage
   //////////////////////////////////////////////////

   always_ff @(posedge txframe_clk)
   begin
      if (!txframe_rst_n)
      begin
         ready_d1 <= 1'b0;
      end
      else
      begin
         ready_d1 <= link_tprt_early_txdata_ready;
      end
   end

   assign jesd_tx_data_ready = ready_d1;

   //////////////////////////////////////////////////
   // Pipeline stages
   //////////////////////////////////////////////////

   csr_decode u_csr_decode (
      .txframe_clk   (txframe_clk),
      .txframe_rst_n (txframe_rst_n),
      .csr_l         (csr_l),
      .csr_n         (csr_n),
      .n_sel         (n_sel),
      .pdlane        (pdlane)
   );

   sample_packer u_sample_packer (
      .jesd_tx_datain (jesd_tx_datain),
      .n_sel          (n_sel),
      .slot_bus       (slot_bus)
   );

   lane_mapper u_lane_mapper (
      .slot_bus (slot_bus),
      .pdlane   (pdlane),
      .ready_d1 (ready_d1),
      .lane_bus (lane_bus)
   );

   link_output u_link_output (
      .txframe_clk            (txframe_clk),
      .txframe_rst_n          (txframe_rst_n),
      .lane_bus               (lane_bus),
      .jesd_tx_data_valid     (jesd_tx_data_valid),
      .ready_d1               (ready_d1),
      .tprt_link_txdata       (tprt_link_txdata),
      .tprt_link_txdata_valid (tprt_link_txdata_valid),
      .tprt_link_txdata_error (tprt_link_txdata_error)
   );

endmodule

// File: sim.f
hw/tx_transport_pkg.sv
hw/csr_decode.sv
hw/sample_packer.sv
hw/lane_mapper.sv
hw/link_output.sv
hw/tx_transport_top.sv
test/tx_transport_checker.sv
test/tb_tx_transport.sv

// File: test/tb_tx_transport.sv
// Testbench for the transmit transport layer, applying a stimulus table and checking via the monitor
`timescale 1ns/1ps

module tb_tx_transport;

   import tx_transport_pkg::*;

   localparam int          RESET_CYCLES = 16;
   localparam int          FLUSH_CYCLES = 4;
   localparam int          MARGIN       = 100;
   localparam logic [31:0] SEED         = 32'h96d3412a;

   logic                txframe_clk;
   logic                txframe_rst_n;
   logic [DATAIN_W-1:0] jesd_tx_datain;
   logic                jesd_tx_data_valid;
   logic                link_tprt_early_txdata_ready;
   logic [CSR_L_W-1:0]  csr_l;
   logic [CSR_N_W-1:0]  csr_n;
   logic                jesd_tx_data_ready;
   logic [LINK_W-1:0]   tprt_link_txdata;
   logic                tprt_link_txdata_valid;
   logic                tprt_link_txdata_error;
   logic                check_en;
   logic [127:0]        test_name;
   logic                table_ready;
   int                  settle;
   int                  data_errs;
   int                  valid_errs;
   int                  error_errs;
   int                  ready_errs;
   int                  checks;

   // Ready and valid modes are 0 for low, 1 for high and 2 for random
   logic [127:0]       row_name  [$];
   logic [CSR_L_W-1:0] row_l     [$];
   logic [CSR_N_W-1:0] row_n     [$];
   logic [1:0]         row_rdy   [$];
   logic [1:0]         row_vld   [$];
   int                 row_count [$];

   tx_transport_top uut (
      .txframe_clk                  (txframe_clk),
      .txframe_rst_n                (txframe_rst_n),
      .jesd_tx_datain               (jesd_tx_datain),
      .jesd_tx_data_valid           (jesd_tx_data_valid),
      .link_tprt_early_txdata_ready (link_tprt_early_txdata_ready),
      .csr_l                        (csr_l),
      .csr_n                        (csr_n),
      .jesd_tx_data_ready           (jesd_tx_data_ready),
      .tprt_link_txdata             (tprt_link_txdata),
      .tprt_link_txdata_valid       (tprt_link_txdata_valid),
      .tprt_link_txdata_error       (tprt_link_txdata_error)
   );

   tx_transport_checker u_checker (
      .txframe_clk                  (txframe_clk),
      .txframe_rst_n                (txframe_rst_n),
      .check_en                     (check_en),
      .test_name                    (test_name),
      .jesd_tx_datain               (jesd_tx_datain),
      .jesd_tx_data_valid           (jesd_tx_data_valid),
      .link_tprt_early_txdata_ready (link_tprt_early_txdata_ready),
      .csr_l                        (csr_l),
      .csr_n                        (csr_n),
      .jesd_tx_data_ready           (jesd_tx_data_ready),
      .tprt_link_txdata             (tprt_link_txdata),
      .tprt_link_txdata_valid       (tprt_link_txdata_valid),
      .tprt_link_txdata_error       (tprt_link_txdata_error),
      .data_errs                    (data_errs),
      .valid_errs                   (valid_errs),
      .error_errs                   (error_errs),
      .ready_errs                   (ready_errs),
      .checks                       (checks)
   );

   initial
   begin
      txframe_clk = 1'b0;
      forever #2 txframe_clk = ~txframe_clk;
   end

   //////////////////////////////////////////////////
   // Table rows and per-cycle drive
   //////////////////////////////////////////////////

   task automatic add_row(input logic [127:0] name, input logic [CSR_L_W-1:0] l,
                          input logic [CSR_N_W-1:0] n, input logic [1:0] rdy,
                          input logic [1:0] vld, input int count);
      row_name.push_back(name);
      row_l.push_back(l);
      row_n.push_back(n);
      row_rdy.push_back(rdy);
      row_vld.push_back(vld);
      row_count.push_back(count);
   endtask

   task automatic build_table();
      add_row("res12_l4", 5'd3, 5'd11, 2'd1, 2'd1, 20);
      add_row("res13_l4", 5'd3, 5'd12, 2'd1, 2'd1, 20);
      add_row("res14_l4", 5'd3, 5'd13, 2'd1, 2'd1, 20);
      add_row("res15_l4", 5'd3, 5'd14, 2'd1, 2'd1, 20);
      add_row("res16_l4", 5'd3, 5'd15, 2'd1, 2'd1, 20);
      add_row("lanes1", 5'd0, 5'd15, 2'd1, 2'd1, 16);
      add_row("lanes2", 5'd1, 5'd13, 2'd1, 2'd1, 16);
      add_row("lanes3", 5'd2, 5'd11, 2'd1, 2'd1, 16);
      add_row("ready_low", 5'd3, 5'd15, 2'd0, 2'd1, 12);
      add_row("ready_rand", 5'd3, 5'd14, 2'd2, 2'd1, 30);
      add_row("valid_rand", 5'd3, 5'd15, 2'd1, 2'd2, 30);
      add_row("idle_no_err", 5'd3, 5'd12, 2'd0, 2'd0, 12);
      add_row("valid_low", 5'd3, 5'd12, 2'd1, 2'd0, 12);
      add_row("bad_n10", 5'd3, 5'd10, 2'd1, 2'd1, 12);
      add_row("bad_n31", 5'd3, 5'd31, 2'd1, 2'd1, 12);
      add_row("mixed_rand", 5'd1, 5'd14, 2'd2, 2'd2, 40);
   endtask

   task automatic drive_cycle(input int row);
      logic [31:0] r;
      test_name = row_name[row];
      // Data compare waits out the CSR register stage
      if (row_l[row] != csr_l || row_n[row] != csr_n)
      begin
         settle = 2;
      end
      csr_l    = row_l[row];
      csr_n    = row_n[row];
      check_en = (settle == 0);
      if (settle > 0)
      begin
         settle = settle - 1;
      end
      r = $urandom;
      link_tprt_early_txdata_ready = (row_rdy[row] == 2'd2) ? r[0] : row_rdy[row][0];
      r = $urandom;
      jesd_tx_data_valid = (row_vld[row] == 2'd2) ? r[0] : row_vld[row][0];
      jesd_tx_datain = {$urandom, $urandom, $urandom, $urandom};
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial
   begin
      void'($urandom(SEED));
      txframe_rst_n                = 1'b0;
      jesd_tx_datain               = '0;
      jesd_tx_data_valid           = 1'b0;
      link_tprt_early_txdata_ready = 1'b0;
      csr_l                        = '0;
      csr_n                        = '0;
      check_en                     = 1'b0;
      test_name                    = "reset";
      settle                       = 0;
      build_table();
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(posedge txframe_clk);
      @(negedge txframe_clk);
      txframe_rst_n = 1'b1;
      for (int row = 0; row < row_count.size(); row++)
      begin
         for (int c = 0; c < row_count[row]; c++)
         begin
            if (c > 0 || row > 0)
            begin
               @(negedge txframe_clk);
            end
            drive_cycle(row);
         end
      end
      // Let the last frames drain through the pipeline
      repeat (FLUSH_CYCLES) @(negedge txframe_clk);
      $display("Errors: data %0d, valid %0d, error flag %0d, ready %0d over %0d checks",
               data_errs, valid_errs, error_errs, ready_errs, checks);
      if (data_errs + valid_errs + error_errs + ready_errs == 0 && checks > 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial
   begin : watchdog
      int limit;
      wait (table_ready === 1'b1);
      limit = RESET_CYCLES + FLUSH_CYCLES + MARGIN;
      foreach (row_count[i])
      begin
         limit = limit + row_count[i];
      end
      repeat (limit) @(posedge txframe_clk);
      $display("Timeout: the run hung and did not finish within %0d cycles", limit);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

// File: test/tx_transport_checker.sv
// Testbench monitor that predicts the transport layer outputs from its inputs and counts mismatches
`timescale 1ns/1ps

module tx_transport_checker (
   input  logic                                  txframe_clk,
   input  logic                                  txframe_rst_n,
   input  logic                                  check_en,
   input  logic [127:0]                          test_name,
   input  logic [tx_transport_pkg::DATAIN_W-1:0] jesd_tx_datain,
   input  logic                                  jesd_tx_data_valid,
   input  logic                                  link_tprt_early_txdata_ready,
   input  logic [tx_transport_pkg::CSR_L_W-1:0]  csr_l,
   input  logic [tx_transport_pkg::CSR_N_W-1:0]  csr_n,
   input  logic                                  jesd_tx_data_ready,
   input  logic [tx_transport_pkg::LINK_W-1:0]   tprt_link_txdata,
   input  logic                                  tprt_link_txdata_valid,
   input  logic                                  tprt_link_txdata_error,
   output int                                    data_errs,
   output int                                    valid_errs,
   output int                                    error_errs,
   output int                                    ready_errs,
   output int                                    checks
);

   import tx_transport_pkg::*;

   int data_cnt  = 0;
   int valid_cnt = 0;
   int error_cnt = 0;
   int ready_cnt = 0;
   int check_cnt = 0;

   // Reference pipeline, one stage behind the inputs
   logic                m_ready_d1;
   logic                m_valid_d1;
   logic [CSR_N_W-1:0]  m_n;
   logic [CSR_L_W-1:0]  m_l;
   logic [127:0]        m_name;
   logic [LINK_W-1:0]   exp_data;
   logic                exp_valid;
   logic                exp_error;

   assign data_errs  = data_cnt;
   assign valid_errs = valid_cnt;
   assign error_errs = error_cnt;
   assign ready_errs = ready_cnt;
   assign checks     = check_cnt;

   //////////////////////////////////////////////////
   // Expected lane words for one frame
   //////////////////////////////////////////////////

   function automatic logic [LINK_W-1:0] expect_lanes(
      input logic [DATAIN_W-1:0] datain,
      input logic [CSR_N_W-1:0]  n_field,
      input logic [CSR_L_W-1:0]  l_field,
      input logic                rdy
   );
      logic [LINK_W-1:0]   result;
      logic [DATAIN_W-1:0] shifted;
      logic [31:0]         sample;
      int                  n;
      int                  off;
      result = '0;
      n = int'(n_field) + 1;
      if (rdy && n >= N_MIN && n <= N_MAX)
      begin
         for (int j = 0; j < SLOTS; j++)
         begin
            shifted = datain >> (j * n);
            sample  = {16'd0, shifted[15:0]} & ((32'd1 << n) - 32'd1);
            // Sample MSB lands on slot bit 15
            sample  = sample << (SLOT_W - n);
            // Even slot in the upper half of its lane
            off = (j / 2) * LANE_W + ((j % 2 == 0) ? SLOT_W : 0);
            if (j / 2 <= int'(l_field))
            begin
               result[off +: SLOT_W] = sample[SLOT_W-1:0];
            end
         end
      end
      return result;
   endfunction

   //////////////////////////////////////////////////
   // Compare, then advance the reference
   //////////////////////////////////////////////////

   always @(posedge txframe_clk)
   begin
      if (!txframe_rst_n)
      begin
         m_ready_d1 = 1'b0;
         m_valid_d1 = 1'b0;
         m_n        = '0;
         m_l        = '0;
         m_name     = test_name;
         exp_data   = '0;
         exp_valid  = 1'b0;
         exp_error  = 1'b0;
      end
      else
      begin
         check_cnt = check_cnt + 1;
         if (jesd_tx_data_ready !== m_ready_d1)
         begin
            ready_cnt = ready_cnt + 1;
            $display("Mismatch %0s jesd_tx_data_ready: expected %b actual %b",
                     m_name, m_ready_d1, jesd_tx_data_ready);
         end
         if (check_en && tprt_link_txdata !== exp_data)
         begin
            data_cnt = data_cnt + 1;
            $display("Mismatch %0s tprt_link_txdata: expected %h actual %h",
                     m_name, exp_data, tprt_link_txdata);
         end
         if (tprt_link_txdata_valid !== exp_valid)
         begin
            valid_cnt = valid_cnt + 1;
            $display("Mismatch %0s tprt_link_txdata_valid: expected %b actual %b",
                     m_name, exp_valid, tprt_link_txdata_valid);
         end
         if (tprt_link_txdata_error !== exp_error)
         begin
            error_cnt = error_cnt + 1;
            $display("Mismatch %0s tprt_link_txdata_error: expected %b actual %b",
                     m_name, exp_error, tprt_link_txdata_error);
         end
         exp_data   = expect_lanes(jesd_tx_datain, m_n, m_l, m_ready_d1);
         exp_error  = m_ready_d1 & ~jesd_tx_data_valid;
         exp_valid  = m_valid_d1;
         m_valid_d1 = jesd_tx_data_valid;
         m_ready_d1 = link_tprt_early_txdata_ready;
         m_n        = csr_n;
         m_l        = csr_l;
         m_name     = test_name;
      end
   end

endmodule
